//--- logic/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// data path and pc width
`define RV_XLEN 32

// register file address width
`define RV_REG_ADDR_W 5

// pc held by the ID/EX register out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- logic/rv_decode_pkg.sv
package rv_decode_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_R      = 7'b0110011,
        OPC_I_BASE = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // func3 of the register-immediate group
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } func3_alu_e;

    // func3 of the branch group
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } func3_br_e;

    // access width for loads and stores
    typedef enum logic [2:0] {
        F3_BYTE = 3'b000,
        F3_HALF = 3'b001,
        F3_WORD = 3'b010
    } func3_mem_e;

    // upper field, ALT picks srai over srli
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } func7_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_LESS_SIGNED, ALU_LESS_UNSIGNED,
        ALU_LEFT_LOGIC, ALU_RIGHT_LOGIC, ALU_RIGHT_ARITH
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {SRC1_REG1, SRC1_PC, SRC1_ZERO} alu_src1_e;

    // second operand source
    typedef enum logic [1:0] {SRC2_REG2, SRC2_IMM, SRC2_FOUR} alu_src2_e;

    typedef enum logic [1:0] {STORE_NONE, STORE_SB, STORE_SH, STORE_SW} store_e;

    typedef enum logic [2:0] {LOAD_NONE, LOAD_LB, LOAD_LH, LOAD_LW} load_e;

    typedef enum logic [2:0] {
        BRANCH_NONE, BRANCH_BEQ, BRANCH_BNE, BRANCH_BLT,
        BRANCH_BGE, BRANCH_BLTU, BRANCH_BGEU
    } branch_e;

    typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR} jump_e;

    // immediate layout chosen by the decoder
    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

endpackage

//--- logic/decode_ctrl_if.sv
`timescale 1ns/1ps

interface decode_ctrl_if;

    // register write-back enable
    logic                     wd;
    rv_decode_pkg::alu_op_e   alu_op;
    rv_decode_pkg::alu_src1_e alu_src1;
    rv_decode_pkg::alu_src2_e alu_src2;
    // memory access widths
    rv_decode_pkg::store_e    store_type;
    rv_decode_pkg::load_e     load_type;
    rv_decode_pkg::branch_e   branch_type;
    rv_decode_pkg::jump_e     jump_kind;
    rv_decode_pkg::imm_fmt_e  imm_fmt;

    // decoder side
    modport producer (
        output wd, alu_op, alu_src1, alu_src2,
        output store_type, load_type, branch_type, jump_kind, imm_fmt
    );

    // immediate generator only needs the format
    modport imm (input imm_fmt);

    // target calculator and pipeline register
    modport consumer (
        input wd, alu_op, alu_src1, alu_src2,
        input store_type, load_type, branch_type, jump_kind
    );

endinterface

//--- logic/ctrl_decoder.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module ctrl_decoder (
    input  logic [`RV_XLEN-1:0] inst_i,
    decode_ctrl_if.producer     ctrl
);

    logic [6:0]             opcode;
    logic [2:0]             func3;
    logic [6:0]             func7;
    // register-immediate sub-decode
    logic                   i_hit;
    rv_decode_pkg::alu_op_e i_op;

    assign opcode = inst_i[6:0];
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];

    // alu op for the I-base group, shifts qualified by func7
    always_comb begin
        i_hit = 1'b1;
        i_op  = rv_decode_pkg::ALU_ADD;
        case (func3)
            rv_decode_pkg::F3_ADD:  i_op = rv_decode_pkg::ALU_ADD;
            rv_decode_pkg::F3_SLT:  i_op = rv_decode_pkg::ALU_LESS_SIGNED;
            rv_decode_pkg::F3_SLTU: i_op = rv_decode_pkg::ALU_LESS_UNSIGNED;
            rv_decode_pkg::F3_XOR:  i_op = rv_decode_pkg::ALU_XOR;
            rv_decode_pkg::F3_OR:   i_op = rv_decode_pkg::ALU_OR;
            rv_decode_pkg::F3_AND:  i_op = rv_decode_pkg::ALU_AND;
            rv_decode_pkg::F3_SLL: begin
                i_op  = rv_decode_pkg::ALU_LEFT_LOGIC;
                i_hit = (func7 == rv_decode_pkg::F7_BASE);
            end
            rv_decode_pkg::F3_SR: begin
                if (func7 == rv_decode_pkg::F7_ALT) begin
                    i_op = rv_decode_pkg::ALU_RIGHT_ARITH;
                end else begin
                    i_op = rv_decode_pkg::ALU_RIGHT_LOGIC;
                end
                i_hit = (func7 == rv_decode_pkg::F7_BASE) || (func7 == rv_decode_pkg::F7_ALT);
            end
            default: i_hit = 1'b0;
        endcase
    end

    always_comb begin
        // anything not matched below leaves all-zero control
        ctrl.wd          = 1'b0;
        ctrl.alu_op      = rv_decode_pkg::ALU_ADD;
        ctrl.alu_src1    = rv_decode_pkg::SRC1_REG1;
        ctrl.alu_src2    = rv_decode_pkg::SRC2_REG2;
        ctrl.store_type  = rv_decode_pkg::STORE_NONE;
        ctrl.load_type   = rv_decode_pkg::LOAD_NONE;
        ctrl.branch_type = rv_decode_pkg::BRANCH_NONE;
        ctrl.jump_kind   = rv_decode_pkg::JUMP_NONE;
        ctrl.imm_fmt     = rv_decode_pkg::IMM_NONE;
        case (opcode)
            // only add kept from R-type
            rv_decode_pkg::OPC_R: begin
                ctrl.wd = (func3 == rv_decode_pkg::F3_ADD) && (func7 == rv_decode_pkg::F7_BASE);
            end
            rv_decode_pkg::OPC_I_BASE: begin
                if (i_hit) begin
                    ctrl.wd       = 1'b1;
                    ctrl.alu_op   = i_op;
                    ctrl.alu_src2 = rv_decode_pkg::SRC2_IMM;
                    ctrl.imm_fmt  = rv_decode_pkg::IMM_I;
                end
            end
            rv_decode_pkg::OPC_LOAD: begin
                case (func3)
                    rv_decode_pkg::F3_BYTE: ctrl.load_type = rv_decode_pkg::LOAD_LB;
                    rv_decode_pkg::F3_HALF: ctrl.load_type = rv_decode_pkg::LOAD_LH;
                    rv_decode_pkg::F3_WORD: ctrl.load_type = rv_decode_pkg::LOAD_LW;
                    default:                ctrl.load_type = rv_decode_pkg::LOAD_NONE;
                endcase
                // address is reg1 plus offset
                if (ctrl.load_type != rv_decode_pkg::LOAD_NONE) begin
                    ctrl.wd       = 1'b1;
                    ctrl.alu_src2 = rv_decode_pkg::SRC2_IMM;
                    ctrl.imm_fmt  = rv_decode_pkg::IMM_I;
                end
            end
            rv_decode_pkg::OPC_STORE: begin
                case (func3)
                    rv_decode_pkg::F3_BYTE: ctrl.store_type = rv_decode_pkg::STORE_SB;
                    rv_decode_pkg::F3_HALF: ctrl.store_type = rv_decode_pkg::STORE_SH;
                    rv_decode_pkg::F3_WORD: ctrl.store_type = rv_decode_pkg::STORE_SW;
                    default:                ctrl.store_type = rv_decode_pkg::STORE_NONE;
                endcase
                // no write-back on stores
                if (ctrl.store_type != rv_decode_pkg::STORE_NONE) begin
                    ctrl.alu_src2 = rv_decode_pkg::SRC2_IMM;
                    ctrl.imm_fmt  = rv_decode_pkg::IMM_S;
                end
            end
            rv_decode_pkg::OPC_BRANCH: begin
                case (func3)
                    rv_decode_pkg::F3_BEQ:  ctrl.branch_type = rv_decode_pkg::BRANCH_BEQ;
                    rv_decode_pkg::F3_BNE:  ctrl.branch_type = rv_decode_pkg::BRANCH_BNE;
                    rv_decode_pkg::F3_BLT:  ctrl.branch_type = rv_decode_pkg::BRANCH_BLT;
                    rv_decode_pkg::F3_BGE:  ctrl.branch_type = rv_decode_pkg::BRANCH_BGE;
                    rv_decode_pkg::F3_BLTU: ctrl.branch_type = rv_decode_pkg::BRANCH_BLTU;
                    rv_decode_pkg::F3_BGEU: ctrl.branch_type = rv_decode_pkg::BRANCH_BGEU;
                    default:                ctrl.branch_type = rv_decode_pkg::BRANCH_NONE;
                endcase
                // compare reg1 against reg2 by subtraction
                if (ctrl.branch_type != rv_decode_pkg::BRANCH_NONE) begin
                    ctrl.alu_op  = rv_decode_pkg::ALU_SUB;
                    ctrl.imm_fmt = rv_decode_pkg::IMM_B;
                end
            end
            // link value pc + 4 for both jumps
            rv_decode_pkg::OPC_JAL: begin
                ctrl.wd        = 1'b1;
                ctrl.alu_src1  = rv_decode_pkg::SRC1_PC;
                ctrl.alu_src2  = rv_decode_pkg::SRC2_FOUR;
                ctrl.jump_kind = rv_decode_pkg::JUMP_JAL;
                ctrl.imm_fmt   = rv_decode_pkg::IMM_J;
            end
            rv_decode_pkg::OPC_JALR: begin
                // jalr only defined with func3 zero
                if (func3 == 3'b000) begin
                    ctrl.wd        = 1'b1;
                    ctrl.alu_src1  = rv_decode_pkg::SRC1_PC;
                    ctrl.alu_src2  = rv_decode_pkg::SRC2_FOUR;
                    ctrl.jump_kind = rv_decode_pkg::JUMP_JALR;
                    ctrl.imm_fmt   = rv_decode_pkg::IMM_I;
                end
            end
            rv_decode_pkg::OPC_AUIPC: begin
                ctrl.wd       = 1'b1;
                ctrl.alu_src1 = rv_decode_pkg::SRC1_PC;
                ctrl.alu_src2 = rv_decode_pkg::SRC2_IMM;
                ctrl.imm_fmt  = rv_decode_pkg::IMM_U;
            end
            // lui is zero + upper immediate
            rv_decode_pkg::OPC_LUI: begin
                ctrl.wd       = 1'b1;
                ctrl.alu_src1 = rv_decode_pkg::SRC1_ZERO;
                ctrl.alu_src2 = rv_decode_pkg::SRC2_IMM;
                ctrl.imm_fmt  = rv_decode_pkg::IMM_U;
            end
            default: ctrl.wd = 1'b0;
        endcase
    end

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module imm_gen (
    input  logic [`RV_XLEN-1:0] inst_i,
    decode_ctrl_if.imm          ctrl,
    output logic [`RV_XLEN-1:0] imm_o
);

    // sign bit shared by every format
    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (ctrl.imm_fmt)
            // loads, jalr, register-immediate ops
            rv_decode_pkg::IMM_I: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
            // offset split around rd field
            rv_decode_pkg::IMM_S: begin
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            // halfword aligned, bit 0 implied
            rv_decode_pkg::IMM_B: begin
                imm_o = {{19{sign}}, sign, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            // upper 20 bits, low 12 cleared
            rv_decode_pkg::IMM_U: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            rv_decode_pkg::IMM_J: begin
                imm_o = {{11{sign}}, sign, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- logic/flow_target.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module flow_target (
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] reg1_data_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    decode_ctrl_if.consumer     ctrl,
    output logic [`RV_XLEN-1:0] branch_target_o,
    output logic [`RV_XLEN-1:0] jmp_target_o,
    output logic                jmp_flag_o
);

    // taken-branch address, qualified later by branch type
    assign branch_target_o = pc_i + imm_i;

    always_comb begin
        case (ctrl.jump_kind)
            // register indirect
            rv_decode_pkg::JUMP_JALR: jmp_target_o = reg1_data_i + imm_i;
            // pc relative
            rv_decode_pkg::JUMP_JAL:  jmp_target_o = pc_i + imm_i;
            default:                  jmp_target_o = '0;
        endcase
    end

    // high for jal and jalr only
    assign jmp_flag_o = (ctrl.jump_kind != rv_decode_pkg::JUMP_NONE);

endmodule

//--- logic/id_ex_reg.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module id_ex_reg (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic [`RV_XLEN-1:0]       inst_i,
    input  logic [`RV_XLEN-1:0]       pc_i,
    input  logic [`RV_XLEN-1:0]       reg1_data_i,
    input  logic [`RV_XLEN-1:0]       reg2_data_i,
    input  logic [`RV_XLEN-1:0]       imm_i,
    input  logic [`RV_XLEN-1:0]       branch_target_i,
    input  logic [`RV_XLEN-1:0]       jmp_target_i,
    input  logic                      jmp_flag_i,
    decode_ctrl_if.consumer           ctrl,
    output logic                      valid_o,
    output logic [3:0]                aluop_o,
    output logic [3:0]                alusel_o,
    output logic [`RV_XLEN-1:0]       pc_o,
    output logic [`RV_XLEN-1:0]       reg1_o,
    output logic [`RV_XLEN-1:0]       reg2_o,
    output logic                      wd_o,
    output logic [`RV_REG_ADDR_W-1:0] wreg_o,
    output logic [`RV_REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`RV_REG_ADDR_W-1:0] reg2_addr_o,
    output logic [2:0]                branch_type_o,
    output logic [`RV_XLEN-1:0]       branch_target_o,
    output logic [1:0]                store_type_o,
    output logic [2:0]                load_type_o,
    output logic                      jmp_flag_o,
    output logic [`RV_XLEN-1:0]       jmp_target_o,
    output logic [`RV_XLEN-1:0]       imm_o
);

    // held instruction, register fields come from here
    logic [`RV_XLEN-1:0] inst_q;

    // control fields, cleared on reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o       <= 1'b0;
            wd_o          <= 1'b0;
            jmp_flag_o    <= 1'b0;
            aluop_o       <= '0;
            alusel_o      <= '0;
            store_type_o  <= rv_decode_pkg::STORE_NONE;
            load_type_o   <= rv_decode_pkg::LOAD_NONE;
            branch_type_o <= rv_decode_pkg::BRANCH_NONE;
            pc_o          <= `RV_RESET_PC;
        end else begin
            valid_o <= valid_i;
            // idle cycles keep the last values
            if (valid_i) begin
                wd_o          <= ctrl.wd;
                jmp_flag_o    <= jmp_flag_i;
                aluop_o       <= ctrl.alu_op;
                // src2 high, src1 low
                alusel_o      <= {ctrl.alu_src2, ctrl.alu_src1};
                store_type_o  <= ctrl.store_type;
                load_type_o   <= ctrl.load_type;
                branch_type_o <= ctrl.branch_type;
                pc_o          <= pc_i;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (valid_i) begin
            inst_q          <= inst_i;
            reg1_o          <= reg1_data_i;
            reg2_o          <= reg2_data_i;
            imm_o           <= imm_i;
            branch_target_o <= branch_target_i;
            jmp_target_o    <= jmp_target_i;
        end
    end

    // rd, rs1, rs2
    assign wreg_o      = inst_q[11:7];
    assign reg1_addr_o = inst_q[19:15];
    assign reg2_addr_o = inst_q[24:20];

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic [`RV_XLEN-1:0]       inst_i,
    input  logic [`RV_XLEN-1:0]       pc_i,
    input  logic [`RV_XLEN-1:0]       reg1_data_i,
    input  logic [`RV_XLEN-1:0]       reg2_data_i,
    output logic                      valid_o,
    output logic [3:0]                aluop_o,
    output logic [3:0]                alusel_o,
    output logic [`RV_XLEN-1:0]       pc_o,
    output logic [`RV_XLEN-1:0]       reg1_o,
    output logic [`RV_XLEN-1:0]       reg2_o,
    output logic                      wd_o,
    output logic [`RV_REG_ADDR_W-1:0] wreg_o,
    output logic [`RV_REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`RV_REG_ADDR_W-1:0] reg2_addr_o,
    output logic [2:0]                branch_type_o,
    output logic [`RV_XLEN-1:0]       branch_target_o,
    output logic [1:0]                store_type_o,
    output logic [2:0]                load_type_o,
    output logic                      jmp_flag_o,
    output logic [`RV_XLEN-1:0]       jmp_target_o,
    output logic [`RV_XLEN-1:0]       imm_o
);

    // combinational decode results ahead of the register
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] branch_target;
    logic [`RV_XLEN-1:0] jmp_target;
    logic                jmp_flag;

    decode_ctrl_if ctrl_bus ();

    ctrl_decoder u_ctrl_decoder (
        .inst_i (inst_i),
        .ctrl   (ctrl_bus.producer)
    );

    imm_gen u_imm_gen (
        .inst_i (inst_i),
        .ctrl   (ctrl_bus.imm),
        .imm_o  (imm)
    );

    flow_target u_flow_target (
        .pc_i            (pc_i),
        .reg1_data_i     (reg1_data_i),
        .imm_i           (imm),
        .ctrl            (ctrl_bus.consumer),
        .branch_target_o (branch_target),
        .jmp_target_o    (jmp_target),
        .jmp_flag_o      (jmp_flag)
    );

    // single pipeline stage, all outputs registered
    id_ex_reg u_id_ex_reg (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .inst_i          (inst_i),
        .pc_i            (pc_i),
        .reg1_data_i     (reg1_data_i),
        .reg2_data_i     (reg2_data_i),
        .imm_i           (imm),
        .branch_target_i (branch_target),
        .jmp_target_i    (jmp_target),
        .jmp_flag_i      (jmp_flag),
        .ctrl            (ctrl_bus.consumer),
        .valid_o         (valid_o),
        .aluop_o         (aluop_o),
        .alusel_o        (alusel_o),
        .pc_o            (pc_o),
        .reg1_o          (reg1_o),
        .reg2_o          (reg2_o),
        .wd_o            (wd_o),
        .wreg_o          (wreg_o),
        .reg1_addr_o     (reg1_addr_o),
        .reg2_addr_o     (reg2_addr_o),
        .branch_type_o   (branch_type_o),
        .branch_target_o (branch_target_o),
        .store_type_o    (store_type_o),
        .load_type_o     (load_type_o),
        .jmp_flag_o      (jmp_flag_o),
        .jmp_target_o    (jmp_target_o),
        .imm_o           (imm_o)
    );

endmodule

//--- tb/decode_stage_assert.sv
`timescale 1ns/1ps

module decode_stage_assert (
    input logic       clk,
    input logic       rst_n_i,
    input logic       valid_i,
    input logic       valid_o,
    input logic       wd_o,
    input logic [1:0] store_type_o,
    input logic [2:0] load_type_o,
    input logic [2:0] branch_type_o,
    input logic       jmp_flag_o
);

    // one memory access kind per instruction
    a_mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !((store_type_o != rv_decode_pkg::STORE_NONE) &&
          (load_type_o != rv_decode_pkg::LOAD_NONE)))
        else $error("store and load type both active");

    // stores and branches never write back
    a_no_writeback: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((store_type_o != rv_decode_pkg::STORE_NONE) ||
         (branch_type_o != rv_decode_pkg::BRANCH_NONE)) |-> !wd_o)
        else $error("write enable set on a store or branch");

    // a jump is never also a branch
    a_jump_not_branch: assert property (@(posedge clk) disable iff (!rst_n_i)
        jmp_flag_o |-> (branch_type_o == rv_decode_pkg::BRANCH_NONE))
        else $error("jump flag set together with a branch type");

    // single cycle latency of the strobe
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        1'b1 |=> (valid_o == $past(valid_i)))
        else $error("valid_o does not follow valid_i by one cycle");

endmodule

//--- tb/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int NUM_CASES    = 29;
    localparam int FIELDS       = 17;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_CASES + 20;

    logic        clk;
    logic        rst_n_i;
    logic        valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic [31:0] reg1_data_i;
    logic [31:0] reg2_data_i;
    logic        valid_o;
    logic [3:0]  aluop_o;
    logic [3:0]  alusel_o;
    logic [31:0] pc_o;
    logic [31:0] reg1_o;
    logic [31:0] reg2_o;
    logic        wd_o;
    logic [4:0]  wreg_o;
    logic [4:0]  reg1_addr_o;
    logic [4:0]  reg2_addr_o;
    logic [2:0]  branch_type_o;
    logic [31:0] branch_target_o;
    logic [1:0]  store_type_o;
    logic [2:0]  load_type_o;
    logic        jmp_flag_o;
    logic [31:0] jmp_target_o;
    logic [31:0] imm_o;

    // flat table of FIELDS words per case
    logic [31:0] case_mem [0:NUM_CASES*FIELDS-1];
    // outstanding cases and the cycle their result is due
    int          pending_idx[$];
    int          pending_due[$];
    int          cycle_cnt     = 0;
    int          error_count   = 0;
    int          checked_count = 0;
    int          last_idx;

    decode_stage DUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .inst_i          (inst_i),
        .pc_i            (pc_i),
        .reg1_data_i     (reg1_data_i),
        .reg2_data_i     (reg2_data_i),
        .valid_o         (valid_o),
        .aluop_o         (aluop_o),
        .alusel_o        (alusel_o),
        .pc_o            (pc_o),
        .reg1_o          (reg1_o),
        .reg2_o          (reg2_o),
        .wd_o            (wd_o),
        .wreg_o          (wreg_o),
        .reg1_addr_o     (reg1_addr_o),
        .reg2_addr_o     (reg2_addr_o),
        .branch_type_o   (branch_type_o),
        .branch_target_o (branch_target_o),
        .store_type_o    (store_type_o),
        .load_type_o     (load_type_o),
        .jmp_flag_o      (jmp_flag_o),
        .jmp_target_o    (jmp_target_o),
        .imm_o           (imm_o)
    );

    bind decode_stage decode_stage_assert u_decode_assert (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .valid_o       (valid_o),
        .wd_o          (wd_o),
        .store_type_o  (store_type_o),
        .load_type_o   (load_type_o),
        .branch_type_o (branch_type_o),
        .jmp_flag_o    (jmp_flag_o)
    );

    // 8 ns period
    always #4 clk = ~clk;

    function automatic logic [31:0] case_field(input int idx, input int field);
        return case_mem[idx*FIELDS + field];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // field order follows the cases file columns
    task automatic compare_outputs(input int idx);
        check_value("pc_o", case_field(idx, 0), pc_o);
        check_value("reg1_o", case_field(idx, 2), reg1_o);
        check_value("reg2_o", case_field(idx, 3), reg2_o);
        check_value("wd_o", case_field(idx, 4), wd_o);
        check_value("wreg_o", case_field(idx, 5), wreg_o);
        check_value("reg1_addr_o", case_field(idx, 6), reg1_addr_o);
        check_value("reg2_addr_o", case_field(idx, 7), reg2_addr_o);
        check_value("aluop_o", case_field(idx, 8), aluop_o);
        check_value("alusel_o", case_field(idx, 9), alusel_o);
        check_value("store_type_o", case_field(idx, 10), store_type_o);
        check_value("load_type_o", case_field(idx, 11), load_type_o);
        check_value("branch_type_o", case_field(idx, 12), branch_type_o);
        check_value("jmp_flag_o", case_field(idx, 13), jmp_flag_o);
        check_value("imm_o", case_field(idx, 14), imm_o);
        check_value("branch_target_o", case_field(idx, 15), branch_target_o);
        check_value("jmp_target_o", case_field(idx, 16), jmp_target_o);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // outputs sampled mid-cycle away from the driving edge
    always @(negedge clk) begin : output_check
        int idx;
        int due;
        if (rst_n_i && valid_o) begin
            if (pending_idx.size() == 0) begin
                error_count++;
                $display("valid_o went high with no instruction outstanding at %0d ns", $time);
            end else begin
                idx = pending_idx.pop_front();
                due = pending_due.pop_front();
                compare_outputs(idx);
                if (cycle_cnt != due) begin
                    error_count++;
                    $display("case %0d came out in cycle %0d instead of %0d", idx, cycle_cnt, due);
                end
                last_idx = idx;
                checked_count++;
            end
        end else if (rst_n_i && checked_count > 0) begin
            // idle cycles must hold every registered value
            compare_outputs(last_idx);
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        inst_i      = '0;
        pc_i        = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        $readmemh("tb/decode_cases.txt", case_mem);
        if (case_mem[NUM_CASES*FIELDS-1] === 'x) begin
            error_count++;
            $display("cases file missing or shorter than %0d cases", NUM_CASES);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk);
        // reset state before anything is issued
        @(negedge clk);
        check_value("valid_o", 0, valid_o);
        check_value("wd_o", 0, wd_o);
        check_value("jmp_flag_o", 0, jmp_flag_o);
        check_value("store_type_o", 0, store_type_o);
        check_value("load_type_o", 0, load_type_o);
        check_value("branch_type_o", 0, branch_type_o);
        check_value("pc_o", 0, pc_o);
        // back to back at one per cycle
        for (int i = 0; i < NUM_CASES; i++) begin
            @(posedge clk);
            valid_i     <= 1'b1;
            pc_i        <= case_field(i, 0);
            inst_i      <= case_field(i, 1);
            reg1_data_i <= case_field(i, 2);
            reg2_data_i <= case_field(i, 3);
            pending_idx.push_back(i);
            // captured at the next edge and seen at the negedge after it
            pending_due.push_back(cycle_cnt + 2);
        end
        @(posedge clk);
        valid_i <= 1'b0;
        pc_i    <= 32'hffff_fff0;
        inst_i  <= '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (pending_idx.size() != 0) begin
            error_count++;
            $display("%0d cases never produced a result", pending_idx.size());
        end
        $display("%0d cases checked, %0d errors", checked_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/decode_ctrl_if.sv
logic/ctrl_decoder.sv
logic/imm_gen.sv
logic/flow_target.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
tb/decode_stage_assert.sv
tb/decode_stage_tb.sv

//--- tb/decode_cases.txt
// pc inst reg1 reg2 | wd wreg reg1_addr reg2_addr aluop alusel store load branch jmp_flag
// imm branch_target jmp_target, one instruction per line, all hex
00000100 002081b3 a0000001 b0000001 1 03 01 02 0 0 0 0 0 0 00000000 00000100 00000000 // add
00000104 fff30293 a0000002 b0000002 1 05 06 1f 0 4 0 0 0 0 ffffffff 00000103 00000000 // addi
00000108 5a544393 a0000003 b0000003 1 07 08 05 2 4 0 0 0 0 000005a5 000006ad 00000000 // xori
0000010c ff056493 a0000004 b0000004 1 09 0a 10 3 4 0 0 0 0 fffffff0 000000fc 00000000 // ori
00000110 0ff67593 a0000005 b0000005 1 0b 0c 1f 4 4 0 0 0 0 000000ff 0000020f 00000000 // andi
00000114 ffb72693 a0000006 b0000006 1 0d 0e 1b 5 4 0 0 0 0 fffffffb 0000010f 00000000 // slti
00000118 7ff83793 a0000007 b0000007 1 0f 10 1f 6 4 0 0 0 0 000007ff 00000917 00000000 // sltiu
0000011c 00391893 a0000008 b0000008 1 11 12 03 7 4 0 0 0 0 00000003 0000011f 00000000 // slli
00000120 007a5993 a0000009 b0000009 1 13 14 07 8 4 0 0 0 0 00000007 00000127 00000000 // srli
00000124 407b5a93 a000000a b000000a 1 15 16 07 9 4 0 0 0 0 00000407 0000052b 00000000 // srai
00000128 abcdebb7 a000000b b000000b 1 17 1b 1c 0 6 0 0 0 0 abcde000 abcde128 00000000 // lui
0000012c 12345c17 a000000c b000000c 1 18 08 03 0 5 0 0 0 0 12345000 1234512c 00000000 // auipc
00000130 ffc08c83 a000000d b000000d 1 19 01 1c 0 4 0 1 0 0 fffffffc 0000012c 00000000 // lb
00000134 7fe19d83 a000000e b000000e 1 1b 03 1e 0 4 0 2 0 0 000007fe 00000932 00000000 // lh
00000138 00812d03 a000000f b000000f 1 1a 02 08 0 4 0 3 0 0 00000008 00000140 00000000 // lw
0000013c fe530fa3 a0000010 b0000010 0 1f 06 05 0 4 1 0 0 0 ffffffff 0000013b 00000000 // sb
00000140 02741223 a0000011 b0000011 0 04 08 07 0 4 2 0 0 0 00000024 00000164 00000000 // sh
00000144 10952023 a0000012 b0000012 0 00 0a 09 0 4 3 0 0 0 00000100 00000244 00000000 // sw
00000148 00208863 a0000013 b0000013 0 10 01 02 1 0 0 0 1 0 00000010 00000158 00000000 // beq
0000014c fe419ce3 a0000014 b0000014 0 19 03 04 1 0 0 0 2 0 fffffff8 00000144 00000000 // bne
00000150 0062c0e3 a0000015 b0000015 0 01 05 06 1 0 0 0 3 0 00000800 00000950 00000000 // blt
00000154 8083d063 a0000016 b0000016 0 00 07 08 1 0 0 0 4 0 fffff000 fffff154 00000000 // bge
00000158 00a4e263 a0000017 b0000017 0 04 09 0a 1 0 0 0 5 0 00000004 0000015c 00000000 // bltu
0000015c 06c5ff63 a0000018 b0000018 0 1e 0b 0c 1 0 0 0 6 0 0000007e 000001da 00000000 // bgeu
00000160 001000ef a0000019 b0000019 1 01 00 01 0 9 0 0 0 1 00000800 00000960 00000960 // jal
00000164 ff9ff2ef a000001a b000001a 1 05 1f 19 0 9 0 0 0 1 fffffff8 0000015c 0000015c // jal
00000168 00c300e7 a000001b b000001b 1 01 06 0c 0 9 0 0 0 1 0000000c 00000174 a0000027 // jalr
0000016c 402081b3 a000001c b000001c 0 03 01 02 0 0 0 0 0 0 00000000 0000016c 00000000 // sub
00000170 ffffffff a000001d b000001d 0 1f 1f 1f 0 0 0 0 0 0 00000000 00000170 00000000 // bad op
